// ==== rtl/backend_top.sv ====
module backend_top (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic                             issue_valid,
    output logic                             issue_ready,
    input  logic [datapath_pkg::XLEN-1:0]    pc0,
    input  logic [datapath_pkg::XLEN-1:0]    pc1,
    input  isa_pkg::uop_e                    op0,
    input  isa_pkg::uop_e                    op1,
    input  logic [isa_pkg::REG_W-1:0]        rs1_0,
    input  logic [isa_pkg::REG_W-1:0]        rs2_0,
    input  logic [isa_pkg::REG_W-1:0]        rd0,
    input  logic [datapath_pkg::XLEN-1:0]    imm0,
    input  logic [isa_pkg::REG_W-1:0]        rs1_1,
    input  logic [isa_pkg::REG_W-1:0]        rs2_1,
    input  logic [isa_pkg::REG_W-1:0]        rd1,
    input  logic [datapath_pkg::XLEN-1:0]    imm1,
    output logic                             wb_valid,
    output logic [datapath_pkg::XLEN-1:0]    wb_pc0,
    output logic [datapath_pkg::XLEN-1:0]    wb_pc1,
    output logic                             wb_we0,
    output logic                             wb_we1,
    output logic [isa_pkg::REG_W-1:0]        wb_rd0,
    output logic [isa_pkg::REG_W-1:0]        wb_rd1,
    output logic [datapath_pkg::XLEN-1:0]    wb_data0,
    output logic [datapath_pkg::XLEN-1:0]    wb_data1
);
    import isa_pkg::*;
    import datapath_pkg::*;

    logic [REG_W-1:0]   raddr0, raddr1, raddr2, raddr3;
    logic [XLEN-1:0]    rdata0, rdata1, rdata2, rdata3;
    logic               div_start, div_ready;
    logic [XLEN-1:0]    dividend, divisor, quotient, remainder;
    logic               mem_rd, mem_wr, mem_rdy;
    logic [DMEM_AW-1:0] mem_addr;
    logic [XLEN-1:0]    mem_wdata, mem_rdata;
    logic               bundle_valid, bundle_done;
    logic [XLEN-1:0]    ex_pc0, ex_pc1;
    uop_e               ex_uop0, ex_uop1;
    logic [REG_W-1:0]   ex_rd0, ex_rd1;
    logic [XLEN-1:0]    alu_result0, alu_result1;
    logic               result0_valid, result1_valid;

    regfile u_regfile (
        .clk(clk), .aresetn(aresetn),
        .raddr0(raddr0), .raddr1(raddr1), .raddr2(raddr2), .raddr3(raddr3),
        .rdata0(rdata0), .rdata1(rdata1), .rdata2(rdata2), .rdata3(rdata3),
        .we0(wb_we0), .we1(wb_we1),
        .waddr0(wb_rd0), .waddr1(wb_rd1),
        .wdata0(wb_data0), .wdata1(wb_data1)
    );

    ex1_stage u_ex1 (
        .clk(clk), .aresetn(aresetn),
        .issue_valid(issue_valid), .issue_ready(issue_ready),
        .pc0(pc0), .pc1(pc1), .op0(op0), .op1(op1),
        .rs1_0(rs1_0), .rs2_0(rs2_0), .rd0(rd0), .imm0(imm0),
        .rs1_1(rs1_1), .rs2_1(rs2_1), .rd1(rd1), .imm1(imm1),
        .raddr0(raddr0), .raddr1(raddr1), .raddr2(raddr2), .raddr3(raddr3),
        .rdata0(rdata0), .rdata1(rdata1), .rdata2(rdata2), .rdata3(rdata3),
        .div_start(div_start), .dividend(dividend), .divisor(divisor),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .bundle_valid(bundle_valid), .ex_pc0(ex_pc0), .ex_pc1(ex_pc1),
        .ex_uop0(ex_uop0), .ex_uop1(ex_uop1), .ex_rd0(ex_rd0), .ex_rd1(ex_rd1),
        .alu_result0(alu_result0), .alu_result1(alu_result1),
        .result0_valid(result0_valid), .result1_valid(result1_valid),
        .bundle_done(bundle_done)
    );

    divider u_divider (
        .clk(clk), .aresetn(aresetn),
        .div_start(div_start), .dividend(dividend), .divisor(divisor),
        .quotient(quotient), .remainder(remainder), .div_ready(div_ready)
    );

    dcache_ram u_dcache (
        .clk(clk), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_rdy(mem_rdy)
    );

    ex2_wb u_ex2_wb (
        .clk(clk), .aresetn(aresetn),
        .bundle_valid(bundle_valid), .pc0_in(ex_pc0), .pc1_in(ex_pc1),
        .uop0(ex_uop0), .uop1(ex_uop1), .rd0_in(ex_rd0), .rd1_in(ex_rd1),
        .alu_result0(alu_result0), .alu_result1(alu_result1),
        .result0_valid(result0_valid), .result1_valid(result1_valid),
        .quotient(quotient), .remainder(remainder), .div_ready(div_ready),
        .dcache_data(mem_rdata), .dcache_ready(mem_rdy),
        .bundle_done(bundle_done), .wb_valid(wb_valid),
        .wb_pc0(wb_pc0), .wb_pc1(wb_pc1), .wb_we0(wb_we0), .wb_we1(wb_we1),
        .wb_rd0(wb_rd0), .wb_rd1(wb_rd1), .wb_data0(wb_data0), .wb_data1(wb_data1)
    );

endmodule

// ==== rtl/datapath_pkg.sv ====
package datapath_pkg;

    localparam int XLEN       = 32;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // one quotient bit per step
    localparam int DIV_STEPS  = XLEN;

endpackage

// ==== rtl/dcache_ram.sv ====
module dcache_ram (
    input  logic                                clk,
    input  logic                                mem_rd,
    input  logic                                mem_wr,
    input  logic [datapath_pkg::DMEM_AW-1:0]    mem_addr,
    input  logic [datapath_pkg::XLEN-1:0]       mem_wdata,
    output logic [datapath_pkg::XLEN-1:0]       mem_rdata,
    output logic                                mem_rdy
);
    import datapath_pkg::*;

    logic [XLEN-1:0] mem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (mem_wr)
            mem[mem_addr] <= mem_wdata;
        mem_rdata <= mem[mem_addr];  // old data on a write
        mem_rdy   <= mem_rd | mem_wr;
    end

endmodule

// ==== rtl/divider.sv ====
module divider (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic                             div_start,
    input  logic [datapath_pkg::XLEN-1:0]    dividend,
    input  logic [datapath_pkg::XLEN-1:0]    divisor,
    output logic [datapath_pkg::XLEN-1:0]    quotient,
    output logic [datapath_pkg::XLEN-1:0]    remainder,
    output logic                             div_ready
);
    import datapath_pkg::*;

    logic [$clog2(DIV_STEPS+1)-1:0] count;
    logic [XLEN-1:0]                dsr;
    logic [XLEN:0]                  partial;
    logic [XLEN:0]                  diff;

    // quotient doubles as the dividend shift register
    assign partial = {remainder, quotient[XLEN-1]};
    assign diff    = partial - {1'b0, dsr};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            count     <= '0;
            div_ready <= 1'b0;
        end else begin
            div_ready <= 1'b0;
            if (div_start) begin
                if (divisor == '0)
                    div_ready <= 1'b1;  // zero divisor, answer at once
                else
                    count <= $bits(count)'(DIV_STEPS);
            end else if (count != '0) begin
                count <= count - 1'b1;
                if (count == 1)
                    div_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            dsr       <= divisor;
            quotient  <= (divisor == '0) ? '1 : dividend;
            remainder <= (divisor == '0) ? dividend : '0;
        end else if (count != '0) begin
            // restore when the trial subtract goes negative
            quotient  <= {quotient[XLEN-2:0], ~diff[XLEN]};
            remainder <= diff[XLEN] ? partial[XLEN-1:0] : diff[XLEN-1:0];
        end
    end

endmodule

// ==== rtl/ex1_stage.sv ====
module ex1_stage (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic                                issue_valid,
    output logic                                issue_ready,
    input  logic [datapath_pkg::XLEN-1:0]       pc0,
    input  logic [datapath_pkg::XLEN-1:0]       pc1,
    input  isa_pkg::uop_e                       op0,
    input  isa_pkg::uop_e                       op1,
    input  logic [isa_pkg::REG_W-1:0]           rs1_0,
    input  logic [isa_pkg::REG_W-1:0]           rs2_0,
    input  logic [isa_pkg::REG_W-1:0]           rd0,
    input  logic [datapath_pkg::XLEN-1:0]       imm0,
    input  logic [isa_pkg::REG_W-1:0]           rs1_1,
    input  logic [isa_pkg::REG_W-1:0]           rs2_1,
    input  logic [isa_pkg::REG_W-1:0]           rd1,
    input  logic [datapath_pkg::XLEN-1:0]       imm1,
    output logic [isa_pkg::REG_W-1:0]           raddr0,
    output logic [isa_pkg::REG_W-1:0]           raddr1,
    output logic [isa_pkg::REG_W-1:0]           raddr2,
    output logic [isa_pkg::REG_W-1:0]           raddr3,
    input  logic [datapath_pkg::XLEN-1:0]       rdata0,
    input  logic [datapath_pkg::XLEN-1:0]       rdata1,
    input  logic [datapath_pkg::XLEN-1:0]       rdata2,
    input  logic [datapath_pkg::XLEN-1:0]       rdata3,
    output logic                                div_start,
    output logic [datapath_pkg::XLEN-1:0]       dividend,
    output logic [datapath_pkg::XLEN-1:0]       divisor,
    output logic                                mem_rd,
    output logic                                mem_wr,
    output logic [datapath_pkg::DMEM_AW-1:0]    mem_addr,
    output logic [datapath_pkg::XLEN-1:0]       mem_wdata,
    output logic                                bundle_valid,
    output logic [datapath_pkg::XLEN-1:0]       ex_pc0,
    output logic [datapath_pkg::XLEN-1:0]       ex_pc1,
    output isa_pkg::uop_e                       ex_uop0,
    output isa_pkg::uop_e                       ex_uop1,
    output logic [isa_pkg::REG_W-1:0]           ex_rd0,
    output logic [isa_pkg::REG_W-1:0]           ex_rd1,
    output logic [datapath_pkg::XLEN-1:0]       alu_result0,
    output logic [datapath_pkg::XLEN-1:0]       alu_result1,
    output logic                                result0_valid,
    output logic                                result1_valid,
    input  logic                                bundle_done
);
    import isa_pkg::*;
    import datapath_pkg::*;

    logic            busy;
    logic            first;  // first cycle after capture
    logic            accept;
    logic [XLEN-1:0] a0, b0, a1, b1;
    logic [XLEN-1:0] imm0_q, imm1_q;
    logic            div0, div1, mem0, mem1;
    logic [XLEN-1:0] mem_sum;

    function automatic logic [XLEN-1:0] alu(uop_e op, logic [XLEN-1:0] a,
                                            logic [XLEN-1:0] b, logic [XLEN-1:0] imm);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ADDI:    return a + imm;
            default: return '0;
        endcase
    endfunction

    assign issue_ready  = ~busy;
    assign accept       = issue_valid & ~busy;
    assign bundle_valid = busy;

    // operands are read in the issue cycle
    assign raddr0 = rs1_0;
    assign raddr1 = rs2_0;
    assign raddr2 = rs1_1;
    assign raddr3 = rs2_1;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            busy    <= 1'b0;
            first   <= 1'b0;
            ex_uop0 <= NOP;
            ex_uop1 <= NOP;
        end else begin
            first <= accept;
            if (accept) begin
                busy    <= 1'b1;
                ex_uop0 <= op0;
                ex_uop1 <= op1;
            end else if (bundle_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_pc0 <= pc0;
            ex_pc1 <= pc1;
            ex_rd0 <= rd0;
            ex_rd1 <= rd1;
            imm0_q <= imm0;
            imm1_q <= imm1;
            a0     <= rdata0;
            b0     <= rdata1;
            a1     <= rdata2;
            b1     <= rdata3;
        end
    end

    assign alu_result0   = alu(ex_uop0, a0, b0, imm0_q);
    assign alu_result1   = alu(ex_uop1, a1, b1, imm1_q);
    assign result0_valid = first & ~ex_uop0[LONG_BIT];  // nop completes here too
    assign result1_valid = first & ~ex_uop1[LONG_BIT];

    // at most one divide and one memory op per bundle
    assign div0 = ex_uop0[LONG_BIT] & ~ex_uop0[MEM_BIT];
    assign div1 = ex_uop1[LONG_BIT] & ~ex_uop1[MEM_BIT];
    assign mem0 = ex_uop0[LONG_BIT] & ex_uop0[MEM_BIT];
    assign mem1 = ex_uop1[LONG_BIT] & ex_uop1[MEM_BIT];

    assign div_start = first & (div0 | div1);
    assign dividend  = div0 ? a0 : a1;
    assign divisor   = div0 ? b0 : b1;

    assign mem_rd    = first & ((mem0 & ~ex_uop0[COND_ST]) | (mem1 & ~ex_uop1[COND_ST]));
    assign mem_wr    = first & ((mem0 & ex_uop0[COND_ST]) | (mem1 & ex_uop1[COND_ST]));
    assign mem_sum   = mem0 ? a0 + imm0_q : a1 + imm1_q;
    assign mem_addr  = mem_sum[DMEM_AW-1:0];  // word index
    assign mem_wdata = mem0 ? b0 : b1;

endmodule

// ==== rtl/ex2_wb.sv ====
module ex2_wb (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic                             bundle_valid,
    input  logic [datapath_pkg::XLEN-1:0]    pc0_in,
    input  logic [datapath_pkg::XLEN-1:0]    pc1_in,
    input  isa_pkg::uop_e                    uop0,
    input  isa_pkg::uop_e                    uop1,
    input  logic [isa_pkg::REG_W-1:0]        rd0_in,
    input  logic [isa_pkg::REG_W-1:0]        rd1_in,
    input  logic [datapath_pkg::XLEN-1:0]    alu_result0,
    input  logic [datapath_pkg::XLEN-1:0]    alu_result1,
    input  logic                             result0_valid,
    input  logic                             result1_valid,
    input  logic [datapath_pkg::XLEN-1:0]    quotient,
    input  logic [datapath_pkg::XLEN-1:0]    remainder,
    input  logic                             div_ready,
    input  logic [datapath_pkg::XLEN-1:0]    dcache_data,
    input  logic                             dcache_ready,
    output logic                             bundle_done,
    output logic                             wb_valid,
    output logic [datapath_pkg::XLEN-1:0]    wb_pc0,
    output logic [datapath_pkg::XLEN-1:0]    wb_pc1,
    output logic                             wb_we0,
    output logic                             wb_we1,
    output logic [isa_pkg::REG_W-1:0]        wb_rd0,
    output logic [isa_pkg::REG_W-1:0]        wb_rd1,
    output logic [datapath_pkg::XLEN-1:0]    wb_data0,
    output logic [datapath_pkg::XLEN-1:0]    wb_data1
);
    import isa_pkg::*;
    import datapath_pkg::*;

    logic            done0, done1;
    logic            hit0, hit1;
    logic            all_done;
    logic [XLEN-1:0] data0_q, data1_q;

    // completion strobe the lane is waiting for
    function automatic logic lane_event(uop_e op, logic alu_v);
        if (!op[LONG_BIT])
            return alu_v;
        return op[MEM_BIT] ? dcache_ready : div_ready;
    endfunction

    function automatic logic [XLEN-1:0] lane_data(uop_e op, logic [XLEN-1:0] alu);
        if (!op[LONG_BIT])
            return alu;
        if (op[MEM_BIT])
            return dcache_data;
        return op[COND_REM] ? remainder : quotient;
    endfunction

    assign hit0     = bundle_valid & ~done0 & lane_event(uop0, result0_valid);
    assign hit1     = bundle_valid & ~done1 & lane_event(uop1, result1_valid);
    assign all_done = done0 & done1;
    assign wb_valid = bundle_done;  // one pulse per bundle

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            done0       <= 1'b0;
            done1       <= 1'b0;
            bundle_done <= 1'b0;
            wb_we0      <= 1'b0;
            wb_we1      <= 1'b0;
        end else begin
            bundle_done <= all_done;
            wb_we0      <= all_done & is_writer(uop0);
            wb_we1      <= all_done & is_writer(uop1);
            if (all_done) begin
                done0 <= 1'b0;
                done1 <= 1'b0;
            end else begin
                if (hit0)
                    done0 <= 1'b1;
                if (hit1)
                    done1 <= 1'b1;
            end
        end
    end

    // early lanes park their data here
    always_ff @(posedge clk) begin
        if (hit0)
            data0_q <= lane_data(uop0, alu_result0);
        if (hit1)
            data1_q <= lane_data(uop1, alu_result1);
        if (all_done) begin
            wb_pc0   <= pc0_in;
            wb_pc1   <= pc1_in;
            wb_rd0   <= rd0_in;
            wb_rd1   <= rd1_in;
            wb_data0 <= data0_q;
            wb_data1 <= data1_q;
        end
    end

endmodule

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    localparam int REG_W = 5;

    // bit 3 marks the long-latency ops, bit 2 the memory ops
    typedef enum logic [3:0] {
        NOP  = 4'b0000,
        ADD  = 4'b0001,
        SUB  = 4'b0010,
        AND  = 4'b0011,
        OR   = 4'b0100,
        XOR  = 4'b0101,
        SLT  = 4'b0110,
        ADDI = 4'b0111,
        DIV  = 4'b1000,
        REM  = 4'b1001,
        LD   = 4'b1100,
        ST   = 4'b1110
    } uop_e;

    localparam int LONG_BIT = 3;  // div, rem, ld, st
    localparam int MEM_BIT  = 2;  // ld, st
    localparam int COND_REM = 0;  // remainder within the divide pair
    localparam int COND_ST  = 1;  // store within the memory pair

    function automatic logic is_writer(uop_e op);
        return !(op == NOP || op == ST);
    endfunction

endpackage

// ==== rtl/regfile.sv ====
module regfile (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic [isa_pkg::REG_W-1:0]        raddr0,
    input  logic [isa_pkg::REG_W-1:0]        raddr1,
    input  logic [isa_pkg::REG_W-1:0]        raddr2,
    input  logic [isa_pkg::REG_W-1:0]        raddr3,
    output logic [datapath_pkg::XLEN-1:0]    rdata0,
    output logic [datapath_pkg::XLEN-1:0]    rdata1,
    output logic [datapath_pkg::XLEN-1:0]    rdata2,
    output logic [datapath_pkg::XLEN-1:0]    rdata3,
    input  logic                             we0,
    input  logic                             we1,
    input  logic [isa_pkg::REG_W-1:0]        waddr0,
    input  logic [isa_pkg::REG_W-1:0]        waddr1,
    input  logic [datapath_pkg::XLEN-1:0]    wdata0,
    input  logic [datapath_pkg::XLEN-1:0]    wdata1
);
    import isa_pkg::*;
    import datapath_pkg::*;

    logic [XLEN-1:0] regs [2**REG_W];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < 2**REG_W; i++)
                regs[i] <= '0;
        end else begin
            if (we0 && waddr0 != '0)
                regs[waddr0] <= wdata0;
            if (we1 && waddr1 != '0)
                regs[waddr1] <= wdata1;  // later write, lane 1 wins
        end
    end

    // x0 is never written so it stays zero
    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; a failing run exits nonzero
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_backend -f verilog.f
./obj_dir/Vtb_backend

// ==== verification/tb_backend.sv ====
module tb_backend;
    import isa_pkg::*;
    import datapath_pkg::*;

    localparam int NUM_BUNDLES  = 400;
    localparam int FILL_BUNDLES = DMEM_WORDS;  // one store per data word first
    localparam int MAX_CYCLES   = 50;          // cycle budget per bundle
    localparam int RESET_CYCLES = 8;

    logic             clk;
    logic             aresetn;
    logic             issue_valid;
    logic             issue_ready;
    logic [XLEN-1:0]  pc0, pc1, imm0, imm1;
    uop_e             op0, op1;
    logic [REG_W-1:0] rs1_0, rs2_0, rd0, rs1_1, rs2_1, rd1;
    logic             wb_valid, wb_we0, wb_we1;
    logic [XLEN-1:0]  wb_pc0, wb_pc1, wb_data0, wb_data1;
    logic [REG_W-1:0] wb_rd0, wb_rd1;

    integer           seed = 32'hd540;
    logic [XLEN-1:0]  model_regs [2**REG_W];
    logic [XLEN-1:0]  model_mem [DMEM_WORDS];

    // current bundle per lane
    uop_e             l_op [2];
    logic [REG_W-1:0] l_rs1 [2];
    logic [REG_W-1:0] l_rs2 [2];
    logic [REG_W-1:0] l_rd [2];
    logic [XLEN-1:0]  l_imm [2];
    logic [XLEN-1:0]  l_pc [2];
    logic [XLEN-1:0]  exp_data [2];

    backend_top dut (
        .clk(clk), .aresetn(aresetn), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .pc0(pc0), .pc1(pc1), .op0(op0), .op1(op1),
        .rs1_0(rs1_0), .rs2_0(rs2_0), .rd0(rd0), .imm0(imm0),
        .rs1_1(rs1_1), .rs2_1(rs2_1), .rd1(rd1), .imm1(imm1),
        .wb_valid(wb_valid), .wb_pc0(wb_pc0), .wb_pc1(wb_pc1),
        .wb_we0(wb_we0), .wb_we1(wb_we1), .wb_rd0(wb_rd0), .wb_rd1(wb_rd1),
        .wb_data0(wb_data0), .wb_data1(wb_data1)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, got);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic uop_e pick_op(input logic [3:0] k);
        case (k)
            4'd0:    return NOP;
            4'd1:    return ADD;
            4'd2:    return SUB;
            4'd3:    return AND;
            4'd4:    return OR;
            4'd5:    return XOR;
            4'd6:    return SLT;
            4'd7:    return ADDI;
            4'd8:    return DIV;
            4'd9:    return REM;
            4'd10:   return LD;
            default: return ST;
        endcase
    endfunction

    function automatic logic is_div(input uop_e op);
        return op == DIV || op == REM;
    endfunction

    function automatic logic is_mem(input uop_e op);
        return op == LD || op == ST;
    endfunction

    function automatic logic [DMEM_AW-1:0] word_index(input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] imm);
        logic [XLEN-1:0] sum;
        sum = a + imm;
        return sum[DMEM_AW-1:0];
    endfunction

    // expected lane result from the op definitions
    function automatic logic [XLEN-1:0] lane_result(input uop_e op, input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b,
                                                    input logic [XLEN-1:0] imm);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            ADDI:    return a + imm;
            DIV:     return (b == '0) ? '1 : a / b;
            REM:     return (b == '0) ? a : a % b;
            LD:      return model_mem[word_index(a, imm)];
            default: return '0;
        endcase
    endfunction

    task automatic draw_bundle(input int idx);
        logic [XLEN-1:0] r;
        for (int i = 0; i < 2; i++) begin
            r = rand_word();
            l_op[i]  = pick_op(4'(r % 12));
            l_rs1[i] = r[8:4];
            l_rs2[i] = r[13:9];
            l_rd[i]  = r[18:14];
            l_imm[i] = rand_word();
        end
        l_pc[0] = XLEN'(idx) << 3;
        l_pc[1] = l_pc[0] + 4;
        if (idx < FILL_BUNDLES) begin
            l_op[0]  = ST;
            l_rs1[0] = '0;
            l_imm[0] = XLEN'(idx);
            l_op[1]  = ADDI;  // fresh random register values from x0
            l_rs1[1] = '0;
        end else begin
            if (is_div(l_op[0]) && is_div(l_op[1]))
                l_op[1] = ADD;
            if (is_mem(l_op[0]) && is_mem(l_op[1]))
                l_op[1] = SLT;
            for (int i = 0; i < 2; i++)
                if (is_div(l_op[i]) && l_imm[i][1:0] == 2'b00)
                    l_rs2[i] = '0;  // zero divisor now and then
            if (is_writer(l_op[0])) begin
                if (l_rs1[1] == l_rd[0])
                    l_rs1[1] = l_rs1[1] + 1'b1;
                if (l_rs2[1] == l_rd[0])
                    l_rs2[1] = l_rs2[1] + 1'b1;
            end
            // pick the word and then the imm that reaches it
            for (int i = 0; i < 2; i++)
                if (is_mem(l_op[i]))
                    l_imm[i] = XLEN'(l_imm[i][DMEM_AW-1:0]) - model_regs[l_rs1[i]];
        end
    endtask

    task automatic drive_inputs();
        pc0   <= l_pc[0];
        pc1   <= l_pc[1];
        op0   <= l_op[0];
        op1   <= l_op[1];
        rs1_0 <= l_rs1[0];
        rs2_0 <= l_rs2[0];
        rd0   <= l_rd[0];
        imm0  <= l_imm[0];
        rs1_1 <= l_rs1[1];
        rs2_1 <= l_rs2[1];
        rd1   <= l_rd[1];
        imm1  <= l_imm[1];
    endtask

    task automatic check_lane(input int lane, input logic [XLEN-1:0] pc, input logic we,
                              input logic [REG_W-1:0] rd, input logic [XLEN-1:0] data);
        check_value($sformatf("wb_pc%0d", lane), pc, l_pc[lane]);
        check_value($sformatf("wb_rd%0d", lane), XLEN'(rd), XLEN'(l_rd[lane]));
        check_value($sformatf("wb_we%0d", lane), XLEN'(we), XLEN'(is_writer(l_op[lane])));
        if (is_writer(l_op[lane]))
            check_value($sformatf("wb_data%0d", lane), data, exp_data[lane]);
    endtask

    task automatic run_bundle(input int idx);
        logic [XLEN-1:0] a [2];
        logic [XLEN-1:0] b [2];
        logic            alu_only;
        int              cycles;
        draw_bundle(idx);
        while (!issue_ready)
            @(posedge clk);
        drive_inputs();
        issue_valid <= 1'b1;
        @(posedge clk);  // accepted here
        issue_valid <= 1'b0;
        assert (!wb_valid) else stop_run("wb_valid pulsed with no bundle in flight");

        // model takes the bundle at issue and writes lane 1 last
        for (int i = 0; i < 2; i++) begin
            a[i] = model_regs[l_rs1[i]];
            b[i] = model_regs[l_rs2[i]];
            exp_data[i] = lane_result(l_op[i], a[i], b[i], l_imm[i]);
        end
        for (int i = 0; i < 2; i++) begin
            if (l_op[i] == ST)
                model_mem[word_index(a[i], l_imm[i])] = b[i];
            if (is_writer(l_op[i]) && l_rd[i] != '0)
                model_regs[l_rd[i]] = exp_data[i];
        end
        alu_only = !(is_div(l_op[0]) || is_mem(l_op[0]) || is_div(l_op[1]) || is_mem(l_op[1]));

        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            assert (!issue_ready) else stop_run("issue_ready rose before the writeback");
        end while (!wb_valid);

        // registered two edges after acceptance and sampled on the third
        if (alu_only)
            check_value("wb_valid delay", XLEN'(cycles - 1), XLEN'(2));
        check_lane(0, wb_pc0, wb_we0, wb_rd0, wb_data0);
        check_lane(1, wb_pc1, wb_we1, wb_rd1, wb_data1);

        @(posedge clk);
        assert (!wb_valid) else stop_run("wb_valid stayed high for more than one cycle");
        assert (issue_ready) else stop_run("issue_ready did not rise after the writeback");
    endtask

    initial begin
        for (int i = 0; i < 2; i++) begin
            l_op[i]  = NOP;
            l_rs1[i] = '0;
            l_rs2[i] = '0;
            l_rd[i]  = '0;
            l_imm[i] = '0;
            l_pc[i]  = '0;
        end
        for (int i = 0; i < 2**REG_W; i++)
            model_regs[i] = '0;
        aresetn     <= 1'b0;
        issue_valid <= 1'b0;
        drive_inputs();

        repeat (RESET_CYCLES) @(posedge clk);
        aresetn <= 1'b1;
        @(posedge clk);
        check_value("issue_ready", XLEN'(issue_ready), XLEN'(1));
        check_value("wb_valid", XLEN'(wb_valid), '0);

        for (int idx = 0; idx < NUM_BUNDLES; idx++)
            run_bundle(idx);

        $display("Everything OK");
        $finish;
    end

    // watchdog
    initial begin
        repeat (RESET_CYCLES + NUM_BUNDLES * MAX_CYCLES) @(posedge clk);
        stop_run("watchdog expired and the back end stopped finishing bundles");
    end

endmodule

// ==== verilog.f ====
rtl/isa_pkg.sv
rtl/datapath_pkg.sv
rtl/regfile.sv
rtl/ex1_stage.sv
rtl/divider.sv
rtl/dcache_ram.sv
rtl/ex2_wb.sv
rtl/backend_top.sv
verification/tb_backend.sv
